// File: flist.f
logic/rv_core_pkg.sv
logic/op_if.sv
logic/fetch_unit.sv
logic/op_queue.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/rv64_core.sv
verif/tb_clkgen.sv
verif/rv64_core_props.sv
verif/rv64_core_tb.sv

// File: logic/exec_unit.sv
module exec_unit (
    input  logic               clk,
    input  logic               reset,        // Active low, async
    op_if.consumer             op_i,         // From the queue
    output logic               redirect_o,   // One cycle after a taken jump
    output rv_core_pkg::xlen_t target_o,     // Where fetch restarts
    output logic [4:0]         rs1_addr_o,
    output logic [4:0]         rs2_addr_o,
    input  rv_core_pkg::xlen_t rs1_data_i,
    input  rv_core_pkg::xlen_t rs2_data_i,
    output logic               rd_we_o,
    output logic [4:0]         rd_addr_o,
    output rv_core_pkg::xlen_t rd_data_o,
    output rv_core_pkg::xlen_t bus_addr_o,
    output rv_core_pkg::data_t bus_wdata_o,
    output logic               bus_we_o,
    output logic               bus_re_o,
    input  rv_core_pkg::data_t bus_rdata_i   // Valid the cycle after bus_re_o
);
    import rv_core_pkg::*;

    instr_u ins;
    xlen_t  imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [5:0] shamt;
    xlen_t  ld_addr, st_addr;
    xlen_t  wb_val, tgt;
    logic   wb_en, take, is_load, is_store;
    logic   fire, start_load;
    logic   redirect_q, load_q, bus_we_q;  // Control state
    xlen_t  target_q, st_addr_q;
    data_t  st_data_q;

    assign ins = op_i.instr;

    // Immediates, all sign-extended to 64 bits
    assign imm_i = {{52{ins.r.funct7[6]}}, ins.r.funct7, ins.r.rs2};
    assign imm_s = {{52{ins.r.funct7[6]}}, ins.r.funct7, ins.r.rd};
    assign imm_b = {{52{ins.r.funct7[6]}}, ins.r.rd[0], ins.r.funct7[5:0],
                    ins.r.rd[4:1], 1'b0};
    assign imm_u = {{32{ins.u.imm[19]}}, ins.u.imm, 12'h000};
    assign imm_j = {{44{ins.u.imm[19]}}, ins.u.imm[7:0], ins.u.imm[8],
                    ins.u.imm[18:9], 1'b0};
    assign shamt = {ins.r.funct7[0], ins.r.rs2};  // RV64 shifts use 6 bits

    assign rs1_addr_o = ins.r.rs1;
    assign rs2_addr_o = ins.r.rs2;
    assign ld_addr    = rs1_data_i + imm_i;
    assign st_addr    = rs1_data_i + imm_s;

    always_comb begin
        wb_en    = 1'b0;
        wb_val   = '0;
        take     = 1'b0;
        tgt      = '0;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (ins.r.opcode)
            OP_LUI: begin
                wb_en  = 1'b1;
                wb_val = imm_u;
            end
            OP_AUIPC: begin
                wb_en  = 1'b1;
                wb_val = op_i.pc + imm_u;  // Relative to this op
            end
            OP_IMM: begin
                wb_en = (ins.r.funct3 == F3_ADD) || (ins.r.funct3 == F3_SLL) ||
                        (ins.r.funct3 == F3_SRL);
                case (ins.r.funct3)
                    F3_SLL:  wb_val = rs1_data_i << shamt;
                    F3_SRL:  wb_val = rs1_data_i >> shamt;  // Logical
                    default: wb_val = rs1_data_i + imm_i;
                endcase
            end
            OP_REG: begin
                wb_en = (ins.r.funct3 == F3_ADD) || (ins.r.funct3 == F3_SLT);
                if (ins.r.funct3 == F3_SLT) begin
                    wb_val = {63'd0, $signed(rs1_data_i) < $signed(rs2_data_i)};
                end else if (ins.r.funct7[5]) begin
                    wb_val = rs1_data_i - rs2_data_i;  // sub
                end else begin
                    wb_val = rs1_data_i + rs2_data_i;
                end
            end
            OP_JAL: begin
                wb_en  = 1'b1;
                wb_val = op_i.pc + 64'd4;  // Link
                take   = 1'b1;
                tgt    = op_i.pc + imm_j;
            end
            OP_JALR: begin
                wb_en  = 1'b1;
                wb_val = op_i.pc + 64'd4;
                take   = 1'b1;
                tgt    = {ld_addr[63:1], 1'b0};  // Low bit cleared
            end
            OP_BRANCH: begin
                take = (ins.r.funct3 == F3_BEQ) && (rs1_data_i == rs2_data_i);
                tgt  = op_i.pc + imm_b;
            end
            OP_LOAD: begin
                is_load = (ins.r.funct3 == F3_WORD);
                wb_en   = is_load;
                wb_val  = {{32{bus_rdata_i[31]}}, bus_rdata_i};  // Sign-extend
            end
            OP_STORE: is_store = (ins.r.funct3 == F3_WORD);
            default: ;  // Retires with no effect
        endcase
    end

    // Load address cycle waits out a pending store and any redirect
    assign start_load = op_i.valid && is_load && !load_q && !redirect_q && !bus_we_q;
    // Ready low on the address cycle of a load and while fetch restarts
    assign op_i.ready = !redirect_q && !(is_load && !load_q);
    assign fire       = op_i.valid && op_i.ready;

    assign rd_we_o   = fire && wb_en;
    assign rd_addr_o = ins.r.rd;
    assign rd_data_o = wb_val;

    assign redirect_o  = redirect_q;
    assign target_o    = target_q;
    assign bus_we_o    = bus_we_q;
    assign bus_re_o    = start_load;
    assign bus_addr_o  = bus_we_q ? st_addr_q : ld_addr;  // Store owns the bus
    assign bus_wdata_o = st_data_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            redirect_q <= 1'b0;
            load_q     <= 1'b0;
            bus_we_q   <= 1'b0;
        end else begin
            redirect_q <= fire && take;
            load_q     <= start_load;  // Data cycle follows
            bus_we_q   <= fire && is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && take) target_q <= tgt;
        if (fire && is_store) begin
            st_addr_q <= st_addr;
            st_data_q <= rs2_data_i[31:0];  // Low word of rs2
        end
    end

endmodule

// File: logic/fetch_unit.sv
module fetch_unit #(
    parameter rv_core_pkg::xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic                clk,
    input  logic                reset,       // Active low, async
    input  rv_core_pkg::instr_u instr_i,     // Word at pc_o, same cycle
    output rv_core_pkg::xlen_t  pc_o,        // Fetch address
    input  logic                redirect_i,  // Taken jump or branch
    input  rv_core_pkg::xlen_t  target_i,    // New fetch address
    op_if.producer              fetch_o
);
    import rv_core_pkg::*;

    xlen_t pc_q;      // Program counter
    logic  active_q;  // Low only in the first cycle after reset
    logic  xfer;      // Op taken by the queue

    assign xfer = fetch_o.valid && fetch_o.ready;

    // Instruction memory is combinational, so the word follows pc directly
    assign pc_o           = pc_q;
    assign fetch_o.valid  = active_q;
    assign fetch_o.pc     = pc_q;
    assign fetch_o.instr  = instr_i;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;  // Start offering one cycle after reset
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            // Redirect wins, the queue drops this cycle's push anyway
            pc_q <= target_i;
        end else if (xfer) begin
            pc_q <= pc_q + 64'd4;  // Next sequential word
        end
        // Otherwise hold pc while the queue is full
    end

endmodule

// File: logic/op_if.sv
// One fetched operation, pc and raw word, under valid/ready
interface op_if;
    import rv_core_pkg::*;

    logic   valid;  // Producer has an op
    logic   ready;  // Consumer takes it this edge
    xlen_t  pc;     // Address of the op
    instr_u instr;  // Raw instruction word

    modport producer (
        output valid,
        output pc,
        output instr,
        input  ready
    );

    modport consumer (
        input  valid,
        input  pc,
        input  instr,
        output ready
    );

endinterface

// File: logic/op_queue.sv
module op_queue #(
    parameter int QUEUE_DEPTH = 2  // Power of two, 2 or more
) (
    input  logic   clk,
    input  logic   reset,    // Active low, async
    input  logic   flush_i,  // Drop everything, same edge as redirect
    op_if.consumer in_i,     // From fetch
    op_if.producer out_o     // To execute
);
    import rv_core_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    xlen_t          pc_mem    [QUEUE_DEPTH];  // Stored pcs
    instr_u         instr_mem [QUEUE_DEPTH];  // Stored words
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;  // One extra bit to tell full from empty
    logic           push;
    logic           pop;

    assign in_i.ready  = (count_q != QUEUE_DEPTH[PTR_W:0]);  // Not full
    assign out_o.valid = (count_q != '0);                     // Not empty
    assign out_o.pc    = pc_mem[rd_ptr_q];
    assign out_o.instr = instr_mem[rd_ptr_q];

    // Flush discards both sides of this edge
    assign push = in_i.valid && in_i.ready && !flush_i;
    assign pop  = out_o.valid && out_o.ready && !flush_i;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr_q]    <= in_i.pc;
            instr_mem[wr_ptr_q] <= in_i.instr;
        end
    end

endmodule

// File: logic/reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               reset,       // Active low, async
    input  logic [4:0]         rs1_addr_i,
    input  logic [4:0]         rs2_addr_i,
    output rv_core_pkg::xlen_t rs1_data_o,
    output rv_core_pkg::xlen_t rs2_data_o,
    input  logic               we_i,
    input  logic [4:0]         rd_addr_i,
    input  rv_core_pkg::xlen_t rd_data_i
);
    import rv_core_pkg::*;

    xlen_t regs [32];  // x0 slot never written

    // Combinational reads, x0 forced to zero
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != 5'd0)) begin
            regs[rd_addr_i] <= rd_data_i;  // Writes to x0 dropped
        end
    end

endmodule

// File: logic/rv64_core.sv
module rv64_core #(
    parameter rv_core_pkg::xlen_t RESET_PC = 64'h0000_0000_8000_0000,
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                              clk,
    input  logic                              reset,        // Active low, async
    input  logic [rv_core_pkg::INSTR_W-1:0]   instr_i,      // Word at pc_o
    output rv_core_pkg::xlen_t                pc_o,
    output rv_core_pkg::xlen_t                bus_addr_o,
    output rv_core_pkg::data_t                bus_wdata_o,
    output logic                              bus_we_o,
    output logic                              bus_re_o,
    input  rv_core_pkg::data_t                bus_rdata_i
);
    import rv_core_pkg::*;

    logic       redirect;
    xlen_t      target;
    logic [4:0] rs1_addr, rs2_addr, rd_addr;
    xlen_t      rs1_data, rs2_data, rd_data;
    logic       rd_we;

    op_if fetch_q ();  // Fetch to queue
    op_if q_exec ();   // Queue to execute

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset(reset), .instr_i(instr_i), .pc_o(pc_o),
        .redirect_i(redirect), .target_i(target), .fetch_o(fetch_q.producer)
    );

    op_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .reset(reset), .flush_i(redirect),
        .in_i(fetch_q.consumer), .out_o(q_exec.producer)
    );

    exec_unit u_exec (
        .clk(clk), .reset(reset), .op_i(q_exec.consumer),
        .redirect_o(redirect), .target_o(target),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rd_we_o(rd_we), .rd_addr_o(rd_addr), .rd_data_o(rd_data),
        .bus_addr_o(bus_addr_o), .bus_wdata_o(bus_wdata_o),
        .bus_we_o(bus_we_o), .bus_re_o(bus_re_o), .bus_rdata_i(bus_rdata_i)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rd_we), .rd_addr_i(rd_addr), .rd_data_i(rd_data)
    );

endmodule

// File: logic/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN_W  = 64;  // Register width
    localparam int DATA_W  = 32;  // Data bus width, word accesses only
    localparam int INSTR_W = 32;  // Instruction width

    typedef logic [XLEN_W-1:0] xlen_t;  // Register value or address
    typedef logic [DATA_W-1:0] data_t;  // One bus word

    // R, I and S forms share one field layout
    // I immediate is {funct7, rs2}, S immediate is {funct7, rd}
    // B form reads the same fields as S
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rform_t;

    // U and J forms, 20 bit immediate field on top
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uform_t;

    // One instruction word, two decodes
    typedef union packed {
        rform_t r;
        uform_t u;
    } instr_u;

    // Major opcodes kept by the core
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // funct3 codes
    localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;  // slli
    localparam logic [2:0] F3_SRL  = 3'b101;  // srli
    localparam logic [2:0] F3_SLT  = 3'b010;  // slt
    localparam logic [2:0] F3_BEQ  = 3'b000;  // beq
    localparam logic [2:0] F3_WORD = 3'b010;  // lw, sw

endpackage

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module rv64_core_tb \
    -f flist.f -o rv64_core_sim
./obj_dir/rv64_core_sim

// File: verif/rv64_core_props.sv
module rv64_core_props (
    input logic               clk,
    input logic               reset,
    input logic               bus_we_i,
    input logic               bus_re_i,
    input logic               redirect_i,
    input rv_core_pkg::xlen_t target_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Store and load never share a bus cycle
    bus_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(bus_we_i && bus_re_i))
        else $error("Bus write and read enables high together");

    // Redirect is a single-cycle pulse
    redirect_pulse: assert property (@(posedge clk) disable iff (!reset)
        redirect_i |=> !redirect_i)
        else $error("Redirect held for two cycles");

    // Jump targets are always halfword aligned
    target_aligned: assert property (@(posedge clk) disable iff (!reset)
        redirect_i |-> !target_i[0])
        else $error("Redirect target has bit 0 set");

endmodule

bind rv64_core rv64_core_props u_props (
    .clk(clk), .reset(reset),
    .bus_we_i(bus_we_o), .bus_re_i(bus_re_o),
    .redirect_i(redirect), .target_i(target)
);

// File: verif/rv64_core_tb.sv
module rv64_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_core_pkg::*;

    localparam xlen_t RESET_PC  = 64'h0000_0000_8000_0000;
    localparam int    ROWS      = 7;
    localparam int    PROG_LEN  = 12;
    localparam int    MAX_ST    = 6;
    localparam xlen_t DATA_ADDR = 64'h100;      // Initial data word lives here
    localparam int    LIMIT     = 100 * ROWS;   // Timeout in cycles

    logic clk, reset;
    logic [31:0] instr_i;
    xlen_t pc_o, bus_addr_o, pc_off;
    data_t bus_wdata_o, bus_rdata_i, rd_next;
    logic bus_we_o, bus_re_o;

    // Test table
    logic [31:0] prog_tab [ROWS][PROG_LEN];
    data_t       init_tab [ROWS];
    int          n_stores [ROWS];
    xlen_t       exp_addr [ROWS][MAX_ST];
    data_t       exp_data [ROWS][MAX_ST];

    logic [31:0] cur_prog [PROG_LEN];  // Program of the running row
    data_t       mem [xlen_t];          // Data memory, word addresses
    xlen_t       st_addr_q [$];         // Observed stores
    data_t       st_data_q [$];
    int          cycles;
    integer      seed;

    tb_clkgen u_clkgen (.clk_o(clk), .reset_o(reset));

    rv64_core #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(2)) uut (
        .clk(clk), .reset(reset), .instr_i(instr_i), .pc_o(pc_o),
        .bus_addr_o(bus_addr_o), .bus_wdata_o(bus_wdata_o),
        .bus_we_o(bus_we_o), .bus_re_o(bus_re_o), .bus_rdata_i(bus_rdata_i)
    );

    // Combinational instruction memory, misaligned or out of range reads zero
    assign pc_off = pc_o - RESET_PC;
    always_comb begin
        if (pc_off >= 64'd48 || pc_off[1:0] != 2'b00) instr_i = 32'h0;
        else instr_i = cur_prog[pc_off[5:2]];
    end

    // Unwritten words get a pattern from the full address
    function automatic data_t read_word(xlen_t addr);
        if (mem.exists(addr)) return mem[addr];
        return ~addr[31:0] ^ addr[63:32];
    endfunction

    // Bus sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (reset && bus_we_o) begin
            st_addr_q.push_back(bus_addr_o);
            st_data_q.push_back(bus_wdata_o);
            mem[bus_addr_o] = bus_wdata_o;
        end
        if (bus_re_o) rd_next = read_word(bus_addr_o);
    end

    always @(posedge clk) begin
        #1 bus_rdata_i = rd_next;  // One-cycle read latency
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run exceeded %0d cycles without finishing", LIMIT);
            $display("Test failures found");
            $fatal(1, "Stopping on timeout");
        end
    end

    // Instruction encoders
    function automatic logic [31:0] itype(opcode_e op, logic [2:0] f3, int rd, int rs1,
                                          int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] rtype(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                          int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic logic [31:0] stype(int rs2, int rs1, int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:5], 5'(rs2), 5'(rs1), F3_WORD, v[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] btype(int rs1, int rs2, int imm);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), F3_BEQ, v[4:1], v[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] utype(opcode_e op, int rd, logic [19:0] imm);
        return {imm, 5'(rd), op};
    endfunction

    function automatic logic [31:0] jtype(int rd, int imm);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), OP_JAL};
    endfunction

    task automatic expect_store(int row, xlen_t addr, xlen_t data);
        exp_addr[row][n_stores[row]] = addr;
        exp_data[row][n_stores[row]] = data[31:0];  // Low word on the bus
        n_stores[row] = n_stores[row] + 1;
    endtask

    task automatic build_table();
        xlen_t ipc;
        logic [31:0] rv;
        logic [11:0] i12;
        for (int r = 0; r < ROWS; r++) begin
            n_stores[r] = 0;
            init_tab[r] = 32'h0;
            for (int k = 0; k < PROG_LEN; k++) prog_tab[r][k] = 32'h0;
        end
        // Row 0: ALU ops on x1 = -7
        prog_tab[0][0]  = itype(OP_IMM, F3_ADD, 1, 0, -7);
        prog_tab[0][1]  = rtype(7'h00, F3_ADD, 3, 1, 1);
        prog_tab[0][2]  = rtype(7'h20, F3_ADD, 4, 0, 1);   // sub
        prog_tab[0][3]  = rtype(7'h00, F3_SLT, 5, 1, 0);
        prog_tab[0][4]  = itype(OP_IMM, F3_SLL, 6, 1, 4);
        prog_tab[0][5]  = itype(OP_IMM, F3_SRL, 7, 1, 60);
        for (int k = 0; k < 5; k++) prog_tab[0][6+k] = stype(3 + k, 0, 'h100 + 4 * k);
        prog_tab[0][11] = jtype(0, 0);
        expect_store(0, 64'h100, 64'hFFFF_FFFF_FFFF_FFF2);  // -14
        expect_store(0, 64'h104, 64'd7);
        expect_store(0, 64'h108, 64'd1);                  // -7 < 0 signed
        expect_store(0, 64'h10C, 64'hFFFF_FFFF_FFFF_FF90);  // -112
        expect_store(0, 64'h110, 64'hF);                  // Logical, 64-bit wide
        // Row 1: lui sign extension, auipc relative to its own pc
        prog_tab[1][0] = utype(OP_LUI, 1, 20'h80001);
        prog_tab[1][1] = itype(OP_IMM, F3_SRL, 2, 1, 32);
        prog_tab[1][2] = utype(OP_AUIPC, 3, 20'h00012);
        prog_tab[1][3] = stype(1, 0, 'h100);
        prog_tab[1][4] = stype(2, 0, 'h104);
        prog_tab[1][5] = stype(3, 0, 'h108);
        prog_tab[1][6] = itype(OP_IMM, F3_SRL, 4, 3, 32);
        prog_tab[1][7] = stype(4, 0, 'h10C);
        prog_tab[1][8] = jtype(0, 0);
        ipc = RESET_PC + 64'd8 + (64'h12 << 12);
        expect_store(1, 64'h100, 64'hFFFF_FFFF_8000_1000);
        expect_store(1, 64'h104, 64'hFFFF_FFFF);          // Upper half all ones
        expect_store(1, 64'h108, ipc);
        expect_store(1, 64'h10C, ipc >> 32);
        // Row 2: lw sign extension, then a load right behind a store
        init_tab[2]    = 32'h9ABC_DEF0;
        prog_tab[2][0] = itype(OP_LOAD, F3_WORD, 1, 0, 'h100);
        prog_tab[2][1] = itype(OP_IMM, F3_SRL, 2, 1, 32);
        prog_tab[2][2] = stype(2, 0, 'h104);
        prog_tab[2][3] = stype(1, 0, 'h108);
        prog_tab[2][4] = itype(OP_LOAD, F3_WORD, 5, 0, 'h108);  // Reads the word just stored
        prog_tab[2][5] = stype(5, 0, 'h10C);
        prog_tab[2][6] = jtype(0, 0);
        expect_store(2, 64'h104, 64'hFFFF_FFFF);
        expect_store(2, 64'h108, 64'h9ABC_DEF0);
        expect_store(2, 64'h10C, 64'h9ABC_DEF0);
        // Row 3: beq taken and not taken, jal link
        prog_tab[3][0] = itype(OP_IMM, F3_ADD, 1, 0, 5);
        prog_tab[3][1] = itype(OP_IMM, F3_ADD, 2, 0, 5);
        prog_tab[3][2] = btype(1, 2, 8);                   // Taken, skips next
        prog_tab[3][3] = stype(1, 0, 'h100);
        prog_tab[3][4] = btype(1, 0, 8);                   // Not taken
        prog_tab[3][5] = stype(2, 0, 'h104);
        prog_tab[3][6] = jtype(3, 8);
        prog_tab[3][7] = stype(1, 0, 'h108);
        prog_tab[3][8] = stype(3, 0, 'h10C);
        prog_tab[3][9] = jtype(0, 0);
        expect_store(3, 64'h104, 64'd5);
        expect_store(3, 64'h10C, RESET_PC + 64'd28);
        // Row 4: jalr with odd offset lands on even address
        prog_tab[4][0] = utype(OP_AUIPC, 1, 20'h0);
        prog_tab[4][1] = itype(OP_JALR, 3'b000, 2, 1, 17);
        prog_tab[4][2] = jtype(0, 0);                      // Wrong path jump, flushed
        prog_tab[4][3] = stype(0, 0, 'h104);
        prog_tab[4][4] = stype(2, 0, 'h108);
        prog_tab[4][5] = jtype(0, 0);
        expect_store(4, 64'h108, RESET_PC + 64'd8);
        // Rows 5 and 6: four random addi immediates each
        for (int r = 5; r < 7; r++) begin
            for (int k = 0; k < 4; k++) begin
                rv  = $random(seed);
                i12 = rv[11:0];
                prog_tab[r][k]     = itype(OP_IMM, F3_ADD, k + 1, 0, int'(i12));
                prog_tab[r][k + 4] = stype(k + 1, 0, 'h100 + 4 * k);
                expect_store(r, 64'h100 + 4 * k, {{52{i12[11]}}, i12});
            end
            prog_tab[r][8] = jtype(0, 0);
        end
    endtask

    task automatic check_value(string what, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "Stopping on first mismatch");
        end
    endtask

    initial begin
        seed        = 32'h849bd13b;
        cycles      = 0;
        bus_rdata_i = 32'h0;
        rd_next     = 32'h0;
        for (int k = 0; k < PROG_LEN; k++) cur_prog[k] = 32'h0;
        build_table();
        for (int r = 0; r < ROWS; r++) begin
            @(posedge clk);
            #1;
            for (int k = 0; k < PROG_LEN; k++) cur_prog[k] = prog_tab[r][k];
            mem.delete();
            mem[DATA_ADDR] = init_tab[r];
            st_addr_q.delete();
            st_data_q.delete();
            u_clkgen.apply_reset();
            // Fetch starts at RESET_PC with the bus idle
            check_value($sformatf("row %0d pc after reset", r), pc_o, RESET_PC);
            check_value($sformatf("row %0d bus enables after reset", r),
                        {62'h0, bus_we_o, bus_re_o}, 64'h0);
            while (st_addr_q.size() < n_stores[r]) @(posedge clk);
            repeat (20) @(posedge clk);  // Room for any stray store
            check_value($sformatf("row %0d store count", r), st_addr_q.size(), n_stores[r]);
            for (int k = 0; k < n_stores[r]; k++) begin
                check_value($sformatf("row %0d store %0d addr", r, k),
                            st_addr_q[k], exp_addr[r][k]);
                check_value($sformatf("row %0d store %0d data", r, k),
                            {32'h0, st_data_q[k]}, {32'h0, exp_data[r][k]});
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: verif/tb_clkgen.sv
module tb_clkgen (
    output logic clk_o,
    output logic reset_o   // Active low
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b0;  // Held in reset until the first apply_reset
    end

    always #5 clk_o = ~clk_o;  // 10 ns period

    // Call shortly after a rising edge, returns with reset released
    task automatic apply_reset();
        reset_o = 1'b0;
        repeat (5) @(posedge clk_o);
        #1 reset_o = 1'b1;
    endtask

endmodule
